// File: common/corep.sv
// ----------------------------
// core package
// shared sizes and types for the memory dependence prediction table
// ----------------------------

package corep;

    // ----------------------------
    // sizes
    // ----------------------------

    // default table depth in sets
    localparam int MDPT_SETS = 64;

    // one prediction per fetch lane, fixed by fetch width
    localparam int MDPT_LANES = 8;

    // lane select width, low pc bits
    localparam int LANE_BITS = 3;

    // address space id width
    localparam int ASID_BITS = 9;

    // set index width at full table depth
    localparam int FETCH_IDX_BITS = 6;

    // instruction word address width
    localparam int PC_BITS = 38;

    // one prediction entry
    localparam int MDP_BITS = 8;

    // ----------------------------
    // types
    // ----------------------------

    // address space id
    typedef logic [ASID_BITS-1:0] ASID_t;

    // fetch set index
    typedef logic [FETCH_IDX_BITS-1:0] fetch_idx_t;

    // word address
    // bits 2:0 pick the lane, bits 8:3 the set
    typedef logic [PC_BITS-1:0] PC38_t;

    // prediction entry
    // bit 7 dependence flag, bits 6:0 store distance
    typedef logic [MDP_BITS-1:0] MDP_t;

    // one set, lane 0 in the low byte
    typedef MDP_t [MDPT_LANES-1:0] MDPT_set_t;

    // ----------------------------
    // control states
    // ----------------------------

    // clear sweeps the table after reset, ready takes updates
    typedef enum logic {
        MDPT_CLEAR = 1'b0,
        MDPT_READY = 1'b1
    } mdpt_state_t;

endpackage

// File: mdpt/mdpt_ctrl.sv
// ----------------------------
// mdpt control
// post-reset clear sweep and write port arbitration
// ----------------------------

module mdpt_ctrl import corep::*; #(
    parameter int SETS = MDPT_SETS
) (
    input  logic                  CLK,
    input  logic                  nRST,

    // update from execute, already hashed
    input  logic                  update_valid,
    input  fetch_idx_t            update_set,
    input  logic [LANE_BITS-1:0]  update_lane,
    input  MDP_t                  update_mdp,

    // array write port
    output logic [MDPT_LANES-1:0] wr_en,
    output fetch_idx_t            wr_set,
    output MDP_t                  wr_mdp,

    // force read responses to zero
    output logic                  read_zero
);

    localparam int SET_BITS = $clog2(SETS);

    mdpt_state_t         state;
    mdpt_state_t         next_state;
    logic [SET_BITS-1:0] sweep_cnt;
    logic                sweep_last;

    // last set of the sweep
    assign sweep_last = (sweep_cnt == SET_BITS'(SETS - 1));

    // ----------------------------
    // state and sweep counter
    // ----------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state     <= MDPT_CLEAR;
            sweep_cnt <= '0;
        end else begin
            state <= next_state;
            // one set per cycle, wraps back to zero at the end
            if (state == MDPT_CLEAR) begin
                sweep_cnt <= sweep_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            MDPT_CLEAR: begin
                if (sweep_last) begin
                    next_state = MDPT_READY;
                end
            end
            // ready is terminal until the next reset
            MDPT_READY: next_state = MDPT_READY;
            default:    next_state = MDPT_CLEAR;
        endcase
    end

    // ----------------------------
    // write port
    // ----------------------------

    always_comb begin
        wr_en     = '0;
        wr_set    = update_set;
        wr_mdp    = update_mdp;
        read_zero = 1'b0;
        case (state)
            MDPT_CLEAR: begin
                // whole set zeroed, updates dropped
                wr_en                  = '1;
                wr_set                 = '0;
                wr_set[SET_BITS-1:0]   = sweep_cnt;
                wr_mdp                 = '0;
                read_zero              = 1'b1;
            end
            MDPT_READY: begin
                // single lane write from the update
                wr_en[update_lane] = update_valid;
            end
            default: begin
                wr_en = '0;
            end
        endcase
    end

endmodule

// File: mdpt/mdpt_index.sv
// ----------------------------
// mdpt index
// asid fold and set/lane hashing for the read and update ports
// ----------------------------

module mdpt_index import corep::*; #(
    parameter int SETS = MDPT_SETS
) (
    input  ASID_t                arch_asid,

    // read request from fetch
    input  logic                 read_req_valid,
    input  fetch_idx_t           read_req_fetch_index,

    // update from execute
    input  logic                 update_valid,
    input  PC38_t                update_pc38,

    // hashed locations
    output fetch_idx_t           read_set,
    output fetch_idx_t           update_set,
    output logic [LANE_BITS-1:0] update_lane,

    // both ports hit the same set this cycle
    output logic                 collide
);

    localparam int SET_BITS = $clog2(SETS);
    localparam int FOLD_HI  = ASID_BITS - FETCH_IDX_BITS;

    fetch_idx_t          asid_fold;
    logic [SET_BITS-1:0] fold_cut;
    logic [SET_BITS-1:0] read_hash;
    logic [SET_BITS-1:0] update_hash;

    // low asid bits xor high asid bits
    assign asid_fold = arch_asid[FETCH_IDX_BITS-1:0]
                     ^ {{(FETCH_IDX_BITS-FOLD_HI){1'b0}}, arch_asid[ASID_BITS-1 -: FOLD_HI]};

    // cut down to the table depth
    assign fold_cut = asid_fold[SET_BITS-1:0];

    // fetch side set
    assign read_hash = read_req_fetch_index[SET_BITS-1:0] ^ fold_cut;

    // execute side set from pc above the lane bits
    assign update_hash = update_pc38[LANE_BITS +: SET_BITS] ^ fold_cut;
    assign update_lane = update_pc38[LANE_BITS-1:0];

    // zero extend to the full index type
    always_comb begin
        read_set                   = '0;
        read_set[SET_BITS-1:0]     = read_hash;
        update_set                 = '0;
        update_set[SET_BITS-1:0]   = update_hash;
    end

    // same set on both ports, feeds the array bypass
    assign collide = read_req_valid && update_valid && (read_hash == update_hash);

endmodule

// File: mdpt/mdpt_array.sv
// ----------------------------
// mdpt array
// lane-banked prediction storage, synchronous set read with bypass
// ----------------------------

module mdpt_array import corep::*; #(
    parameter int SETS = MDPT_SETS
) (
    input  logic                  CLK,
    input  logic                  nRST,

    // write port from control
    input  logic [MDPT_LANES-1:0] wr_en,
    input  fetch_idx_t            wr_set,
    input  MDP_t                  wr_mdp,

    // read port
    input  logic                  read_req_valid,
    input  fetch_idx_t            read_set,
    input  logic                  read_zero,
    input  logic                  collide,

    // registered set, one cycle after the read
    output MDPT_set_t             read_resp_mdp_by_lane
);

    localparam int SET_BITS = $clog2(SETS);

    logic [SET_BITS-1:0] wr_addr;
    logic [SET_BITS-1:0] rd_addr;
    MDPT_set_t           bank_rd;
    MDPT_set_t           rd_next;

    // only the low index bits address the banks
    assign wr_addr = wr_set[SET_BITS-1:0];
    assign rd_addr = read_set[SET_BITS-1:0];

    // ----------------------------
    // lane banks
    // ----------------------------

    for (genvar lane = 0; lane < MDPT_LANES; lane++) begin : g_lane
        // one entry per set for this lane
        MDP_t bank [SETS];

        always_ff @(posedge CLK) begin
            if (wr_en[lane]) begin
                bank[wr_addr] <= wr_mdp;
            end
        end

        // raw read of the addressed set
        assign bank_rd[lane] = bank[rd_addr];
    end

    // ----------------------------
    // read mux and response
    // ----------------------------

    always_comb begin
        rd_next = bank_rd;
        // same-cycle update shows up in its lane
        for (int l = 0; l < MDPT_LANES; l++) begin
            if (collide && wr_en[l]) begin
                rd_next[l] = wr_mdp;
            end
        end
        // table contents not valid yet during clear
        if (read_zero) begin
            rd_next = '0;
        end
    end

    // response holds when there is no read
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            read_resp_mdp_by_lane <= '0;
        end else if (read_req_valid) begin
            read_resp_mdp_by_lane <= rd_next;
        end
    end

endmodule

// File: mdpt/mdpt.sv
// ----------------------------
// mdpt core
// joins control, index hashing and storage of the prediction table
// ----------------------------

module mdpt import corep::*; #(
    parameter int SETS = MDPT_SETS
) (
    input  logic       CLK,
    input  logic       nRST,

    // current address space
    input  ASID_t      arch_asid,

    // fetch read request
    input  logic       read_req_valid,
    input  fetch_idx_t read_req_fetch_index,

    // execute update
    input  logic       update_valid,
    input  PC38_t      update_pc38,
    input  MDP_t       update_mdp,

    // one prediction per lane
    output MDPT_set_t  read_resp_mdp_by_lane
);

    // hashed locations
    fetch_idx_t            read_set;
    fetch_idx_t            update_set;
    logic [LANE_BITS-1:0]  update_lane;
    logic                  collide;

    // array write port
    logic [MDPT_LANES-1:0] wr_en;
    fetch_idx_t            wr_set;
    MDP_t                  wr_mdp;
    logic                  read_zero;

    // ----------------------------
    // hashing
    // ----------------------------

    mdpt_index #(
        .SETS(SETS)
    ) i_index (
        .arch_asid            (arch_asid),
        .read_req_valid       (read_req_valid),
        .read_req_fetch_index (read_req_fetch_index),
        .update_valid         (update_valid),
        .update_pc38          (update_pc38),
        .read_set             (read_set),
        .update_set           (update_set),
        .update_lane          (update_lane),
        .collide              (collide)
    );

    // ----------------------------
    // control
    // ----------------------------

    mdpt_ctrl #(
        .SETS(SETS)
    ) i_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .update_valid (update_valid),
        .update_set   (update_set),
        .update_lane  (update_lane),
        .update_mdp   (update_mdp),
        .wr_en        (wr_en),
        .wr_set       (wr_set),
        .wr_mdp       (wr_mdp),
        .read_zero    (read_zero)
    );

    // ----------------------------
    // storage
    // ----------------------------

    mdpt_array #(
        .SETS(SETS)
    ) i_array (
        .CLK                   (CLK),
        .nRST                  (nRST),
        .wr_en                 (wr_en),
        .wr_set                (wr_set),
        .wr_mdp                (wr_mdp),
        .read_req_valid        (read_req_valid),
        .read_set              (read_set),
        .read_zero             (read_zero),
        .collide               (collide),
        .read_resp_mdp_by_lane (read_resp_mdp_by_lane)
    );

endmodule

// File: src/mdpt_wrapper.sv
// ----------------------------
// mdpt wrapper
// registers every input and the read response around the table core
// ----------------------------

module mdpt_wrapper import corep::*; #(
    parameter int SETS = MDPT_SETS
) (
    input  logic       CLK,
    input  logic       nRST,

    // arch state
    input  ASID_t      next_arch_asid,

    // read request from fetch
    input  logic       next_read_req_valid,
    input  fetch_idx_t next_read_req_fetch_index,

    // update from execute
    input  logic       next_update_valid,
    input  PC38_t      next_update_pc38,
    input  MDP_t       next_update_mdp,

    // registered read response
    output MDPT_set_t  last_read_resp_mdp_by_lane
);

    // core side copies
    ASID_t      arch_asid;
    logic       read_req_valid;
    fetch_idx_t read_req_fetch_index;
    logic       update_valid;
    PC38_t      update_pc38;
    MDP_t       update_mdp;
    MDPT_set_t  read_resp_mdp_by_lane;

    // ----------------------------
    // table core
    // ----------------------------

    mdpt #(
        .SETS(SETS)
    ) i_core (
        .CLK                   (CLK),
        .nRST                  (nRST),
        .arch_asid             (arch_asid),
        .read_req_valid        (read_req_valid),
        .read_req_fetch_index  (read_req_fetch_index),
        .update_valid          (update_valid),
        .update_pc38           (update_pc38),
        .update_mdp            (update_mdp),
        .read_resp_mdp_by_lane (read_resp_mdp_by_lane)
    );

    // ----------------------------
    // boundary registers
    // ----------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            arch_asid                  <= '0;
            read_req_valid             <= 1'b0;
            read_req_fetch_index       <= '0;
            update_valid               <= 1'b0;
            update_pc38                <= '0;
            update_mdp                 <= '0;
            last_read_resp_mdp_by_lane <= '0;
        end else begin
            // asid sampled every cycle
            arch_asid                  <= next_arch_asid;
            // fetch side
            read_req_valid             <= next_read_req_valid;
            read_req_fetch_index       <= next_read_req_fetch_index;
            // execute side
            update_valid               <= next_update_valid;
            update_pc38                <= next_update_pc38;
            update_mdp                 <= next_update_mdp;
            // response out, follows the core every cycle
            last_read_resp_mdp_by_lane <= read_resp_mdp_by_lane;
        end
    end

endmodule

// File: sim/mdpt_tb.sv
// ------------------------------
// mdpt testbench
// drives the registered table wrapper and checks reads against a model
// ------------------------------

module mdpt_tb import corep::*; ();

    localparam int SETS    = 64;
    localparam int LATENCY = 3;

    logic       CLK;
    logic       nRST;
    ASID_t      next_arch_asid;
    logic       next_read_req_valid;
    fetch_idx_t next_read_req_fetch_index;
    logic       next_update_valid;
    PC38_t      next_update_pc38;
    MDP_t       next_update_mdp;
    MDPT_set_t  last_read_resp_mdp_by_lane;

    // reference table, set by lane
    MDP_t model [SETS][MDPT_LANES];
    // low while the clear sweep drops updates
    logic model_live;

    // expected responses in issue order
    MDPT_set_t exp_q[$];
    int        due_q[$];
    logic      lane_q[$];

    int     cyc;
    int     n_checks;
    int     err_value;
    int     err_other;
    integer seed;

    mdpt_wrapper #(
        .SETS(SETS)
    ) i_dut (
        .CLK                        (CLK),
        .nRST                       (nRST),
        .next_arch_asid             (next_arch_asid),
        .next_read_req_valid        (next_read_req_valid),
        .next_read_req_fetch_index  (next_read_req_fetch_index),
        .next_update_valid          (next_update_valid),
        .next_update_pc38           (next_update_pc38),
        .next_update_mdp            (next_update_mdp),
        .last_read_resp_mdp_by_lane (last_read_resp_mdp_by_lane)
    );

    // ------------------------------
    // clock and cycle count
    // ------------------------------

    initial CLK = 1'b0;
    always #2 CLK = ~CLK;

    always @(posedge CLK) cyc <= cyc + 1;

    // ------------------------------
    // reference model
    // ------------------------------

    // low six asid bits against the top three
    function automatic fetch_idx_t asid_fold(ASID_t asid);
        return asid[5:0] ^ {3'b000, asid[8:6]};
    endfunction

    // expected set for a fetch index under an asid
    function automatic MDPT_set_t ref_set(ASID_t asid, fetch_idx_t idx);
        fetch_idx_t s;
        MDPT_set_t  r;
        s = idx ^ asid_fold(asid);
        for (int l = 0; l < MDPT_LANES; l++) begin
            r[l] = model[s][l];
        end
        return r;
    endfunction

    // set from pc bits 8:3, lane from 2:0
    task automatic model_write(ASID_t asid, PC38_t pc, MDP_t mdp);
        fetch_idx_t s;
        s = pc[8:3] ^ asid_fold(asid);
        model[s][pc[2:0]] = mdp;
    endtask

    task automatic model_clear();
        for (int s = 0; s < SETS; s++) begin
            for (int l = 0; l < MDPT_LANES; l++) begin
                model[s][l] = '0;
            end
        end
    endtask

    // ------------------------------
    // compare tasks and process
    // ------------------------------

    task automatic check_set(MDPT_set_t got, MDPT_set_t exp);
        n_checks++;
        if (got !== exp) begin
            err_value++;
            $display("[FAIL] last_read_resp_mdp_by_lane: got %h, expected %h", got, exp);
        end
    endtask

    task automatic check_mdp(int lane, MDP_t got, MDP_t exp);
        n_checks++;
        if (got !== exp) begin
            err_value++;
            $display("[FAIL] last_read_resp_mdp_by_lane lane %0d: got %h, expected %h",
                     lane, got, exp);
        end
    endtask

    // response is stable one unit after its edge
    always @(posedge CLK) begin
        #1;
        while (due_q.size() > 0 && due_q[0] == cyc) begin
            if (lane_q[0]) begin
                for (int l = 0; l < MDPT_LANES; l++) begin
                    check_mdp(l, last_read_resp_mdp_by_lane[l], exp_q[0][l]);
                end
            end else begin
                check_set(last_read_resp_mdp_by_lane, exp_q[0]);
            end
            exp_q.delete(0);
            due_q.delete(0);
            lane_q.delete(0);
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------

    // one input cycle, then on to the next drive point
    task automatic drive(ASID_t asid, logic rd, fetch_idx_t idx, logic up, PC38_t pc,
                         MDP_t mdp, logic per_lane);
        next_arch_asid            = asid;
        next_read_req_valid       = rd;
        next_read_req_fetch_index = idx;
        next_update_valid         = up;
        next_update_pc38          = pc;
        next_update_mdp           = mdp;
        // update goes first, a same-set read this cycle sees it
        if (up && model_live) begin
            model_write(asid, pc, mdp);
        end
        if (rd) begin
            exp_q.push_back(ref_set(asid, idx));
            due_q.push_back(cyc + LATENCY);
            lane_q.push_back(per_lane);
        end
        @(posedge CLK);
        #1;
    endtask

    task automatic read_fetch(ASID_t asid, fetch_idx_t idx, logic per_lane);
        drive(asid, 1'b1, idx, 1'b0, '0, '0, per_lane);
    endtask

    task automatic train_entry(ASID_t asid, PC38_t pc, MDP_t mdp);
        drive(asid, 1'b0, '0, 1'b1, pc, mdp, 1'b0);
    endtask

    task automatic idle_cycles(int n);
        for (int i = 0; i < n; i++) begin
            drive('0, 1'b0, '0, 1'b0, '0, '0, 1'b0);
        end
    endtask

    // idle until every issued read was checked
    task automatic wait_drain();
        int t;
        t = 0;
        while (due_q.size() > 0 && t < 20) begin
            idle_cycles(1);
            t++;
        end
        if (due_q.size() > 0) begin
            err_other++;
            $display("read responses still outstanding after 20 idle cycles");
        end
    endtask

    // table is zero once the sweep is done
    task automatic apply_reset();
        nRST = 1'b0;
        model_clear();
        repeat (8) @(posedge CLK);
        #1;
        nRST = 1'b1;
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------

    initial begin
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        seed                      = 66272;
        nRST                      = 1'b0;
        next_arch_asid            = '0;
        next_read_req_valid       = 1'b0;
        next_read_req_fetch_index = '0;
        next_update_valid         = 1'b0;
        next_update_pc38          = '0;
        next_update_mdp           = '0;
        model_live                = 1'b0;

        apply_reset();
        idle_cycles(SETS + 4);
        model_live = 1'b1;

        // every set zero after the sweep
        for (int s = 0; s < SETS; s++) begin
            read_fetch(9'h000, fetch_idx_t'(s), 1'b0);
        end
        wait_drain();

        // all eight lanes of one set
        for (int l = 0; l < MDPT_LANES; l++) begin
            train_entry(9'h1A5, {29'h0ABCD, 6'd21, 3'(l)}, MDP_t'(8'h80 | (l * 5 + 1)));
        end
        read_fetch(9'h1A5, 6'd21, 1'b0);
        wait_drain();

        // fold of 0x0c8 is 0x0b, fold of 0x041 is zero like asid 0
        train_entry(9'h000, {29'h0, 6'd12, 3'd4}, 8'hC7);
        read_fetch(9'h0C8, 6'd12, 1'b0);
        read_fetch(9'h0C8, 6'd7, 1'b0);
        read_fetch(9'h041, 6'd12, 1'b0);
        train_entry(9'h0C8, {29'h1, 6'd30, 3'd6}, 8'h5A);
        read_fetch(9'h000, 6'd30, 1'b0);
        read_fetch(9'h000, 6'd30 ^ 6'h0B, 1'b0);
        wait_drain();

        // same-cycle update and read of one set
        for (int l = 0; l < MDPT_LANES; l++) begin
            train_entry(9'h000, {29'h0, 6'd40, 3'(l)}, MDP_t'(8'h10 + l));
        end
        drive(9'h000, 1'b1, 6'd40, 1'b1, {29'h0, 6'd40, 3'd3}, 8'hEE, 1'b1);
        read_fetch(9'h000, 6'd40, 1'b1);
        wait_drain();

        // a read every cycle, random updates mixed in
        for (int i = 0; i < 2000; i++) begin
            r0 = $random(seed);
            r1 = $random(seed);
            r2 = $random(seed);
            drive(r0[8:0], 1'b1, r0[14:9], r0[15], {r1[28:0], r2[8:0]}, r2[16:9], 1'b0);
        end
        wait_drain();

        // second reset, updates during the sweep must vanish
        model_live = 1'b0;
        apply_reset();
        // reads of high sets not yet swept still come back zero
        for (int i = 0; i < 16; i++) begin
            drive(9'h000, 1'b1, 6'(63 - i), 1'b1, {29'h0, 6'(i), 3'(i)},
                  MDP_t'(8'hA0 + i), 1'b0);
        end
        idle_cycles(SETS);
        model_live = 1'b1;
        for (int s = 0; s < 16; s++) begin
            read_fetch(9'h000, fetch_idx_t'(s), 1'b0);
        end
        wait_drain();

        $display("summary: %0d checks, %0d value errors, %0d other errors",
                 n_checks, err_value, err_other);
        if (err_value == 0 && err_other == 0 && n_checks > 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // hard limit on run time
    initial begin
        #40000;
        $display("simulation did not finish within its time limit");
        $display("Errors found");
        $finish;
    end

endmodule

// File: compile.f
common/corep.sv
mdpt/mdpt_ctrl.sv
mdpt/mdpt_index.sv
mdpt/mdpt_array.sv
mdpt/mdpt.sv
src/mdpt_wrapper.sv
sim/mdpt_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the mdpt testbench with verilator and run it
# the run passes only when the simulator prints the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module mdpt_tb -f compile.f -o mdpt_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/mdpt_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "No errors"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
